// ==== rtl/s16b_bus_pkg.sv ====
package s16b_bus_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 23;     // Word address, bits 23..1

    // Fixed map, region is address bits 23..21
    typedef enum logic [2:0] {
        rom0     = 3'd0,
        rom1     = 3'd1,
        rom2     = 3'd2,
        work_ram = 3'd3,
        obj_ram  = 3'd4,
        tile_ram = 3'd5,
        palette  = 3'd6,
        io       = 3'd7
    } region_e;

    typedef struct packed {
        logic [ADDR_W:1]   addr;
        logic [DATA_W-1:0] wdata;
        logic              rnw;
        logic [1:0]        dsn;     // {UDSn, LDSn}
    } s16b_host_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
        logic mul;      // 5797 only
        logic tbank;
    } s16b_cs_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
    } s16b_mem_cs_t;

    typedef struct packed {
        logic [DATA_W-1:0] chr_data;
        logic [DATA_W-1:0] pal_data;
        logic [DATA_W-1:0] obj_data;
    } s16b_vid_rd_t;

endpackage

// ==== rtl/s16b_board_pkg.sv ====
package s16b_board_pkg;

    localparam int ROM_AW  = 18;    // 512 kB per bank window
    localparam int TBANK_W = 6;

    // Board variants handled by the decoder
    typedef enum logic [2:0] {
        pcb_5521,
        pcb_5358_small,
        pcb_5358_large,
        pcb_5797,
        pcb_korean
    } pcb_e;

    // Address bits 13..12 inside the 5797 system register region
    typedef enum logic [1:0] {
        sel_mul   = 2'd0,
        sel_timer = 2'd1,   // Timer not fitted here
        sel_tbank = 2'd2
    } sysreg_sel_e;

    localparam logic [2:0] SYSREG_REGION = 3'd1;  // 5797 peripherals
    localparam logic [2:0] TBANK_REGION  = 3'd2;  // Tile bank on the other boards

endpackage

// ==== rtl/s16b_region_decode.sv ====
`timescale 1ns/1ns

module s16b_region_decode (
    input  s16b_board_pkg::pcb_e           pcb,
    input  logic [s16b_bus_pkg::ADDR_W:1]  addr,
    output s16b_bus_pkg::region_e          region,
    output logic [s16b_board_pkg::ROM_AW:1] rom_addr
);

    import s16b_bus_pkg::*;
    import s16b_board_pkg::*;

    logic [1:0] bank;

    // Top three address bits name the region
    assign region = region_e'(addr[ADDR_W:ADDR_W-2]);

    always_comb begin
        case (region)
            rom0:    bank = 2'd0;
            rom1:    bank = 2'd1;
            rom2:    bank = 2'd2;
            default: bank = 2'd0;
        endcase
    end

    // Bank placement depends on the ROM board fitted
    always_comb begin
        case (pcb)
            pcb_5797: begin
                rom_addr = addr[18:1];     // Single flat window
            end
            pcb_5358_large: begin
                rom_addr = {bank, addr[16:1]};
            end
            pcb_5358_small: begin
                rom_addr = {1'b0, bank, addr[15:1]};
            end
            pcb_korean: begin
                rom_addr = {1'b0, addr[17:1]};
            end
            default: begin
                // 5521 and alike, two banks of 256 kB
                rom_addr = {bank[0], addr[17:1]};
            end
        endcase
    end

endmodule

// ==== rtl/s16b_chip_select.sv ====
`timescale 1ns/1ns

module s16b_chip_select (
    input  logic                          clk,
    input  logic                          rst,
    input  s16b_board_pkg::pcb_e          pcb,
    input  logic                          bus_active,
    input  s16b_bus_pkg::region_e         region,
    input  s16b_bus_pkg::s16b_host_req_t  req_q,
    output s16b_bus_pkg::s16b_cs_t        cs
);

    import s16b_bus_pkg::*;
    import s16b_board_pkg::*;

    s16b_cs_t    cs_next;
    sysreg_sel_e sel;

    assign sel = sysreg_sel_e'(req_q.addr[13:12]);

    always_comb begin
        cs_next = '0;
        if (pcb == pcb_5797) begin
            cs_next.rom = (region == rom0) && req_q.rnw;
        end else begin
            cs_next.rom = (region inside {rom0, rom1, rom2}) && req_q.rnw;
        end
        cs_next.ram  = region == work_ram;
        cs_next.vram = (region == tile_ram) && !req_q.addr[16];
        cs_next.chr  = (region == tile_ram) && req_q.addr[16];   // Upper half is text RAM
        cs_next.obj  = region == obj_ram;
        cs_next.pal  = region == palette;

        if (pcb == pcb_5797) begin
            if (3'(region) == SYSREG_REGION) begin
                case (sel)
                    sel_mul:   cs_next.mul   = 1'b1;
                    sel_tbank: cs_next.tbank = !req_q.rnw;
                    default:   ;                     // Timer and spare slot
                endcase
            end
        end else begin
            cs_next.tbank = (3'(region) == TBANK_REGION) && !req_q.rnw;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (bus_active) begin
            cs <= cs_next;
        end else begin
            cs <= '0;
        end
    end

endmodule

// ==== rtl/s16b_sys_regs.sv ====
`timescale 1ns/1ns

module s16b_sys_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cs_mul,
    input  logic                                cs_tbank,
    input  logic                                wr_stb,
    input  s16b_bus_pkg::s16b_host_req_t        req_q,
    output logic [s16b_bus_pkg::DATA_W-1:0]     mul_rdata,
    output logic [s16b_board_pkg::TBANK_W-1:0]  tile_bank
);

    import s16b_bus_pkg::*;

    typedef enum logic [1:0] {
        mreg_a  = 2'd0,
        mreg_b  = 2'd1,
        mreg_hi = 2'd2,
        mreg_lo = 2'd3
    } mul_reg_e;

    logic                       wr;
    mul_reg_e                   mreg;
    logic signed [DATA_W-1:0]   op_a;
    logic signed [DATA_W-1:0]   op_b;
    logic signed [2*DATA_W-1:0] product;

    assign wr   = wr_stb && !req_q.rnw;
    assign mreg = mul_reg_e'(req_q.addr[2:1]);

    // Two 3-bit tile bank fields, only the low byte lane is wired
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (wr && cs_tbank && !req_q.dsn[0]) begin
            if (req_q.addr[1]) tile_bank[5:3] <= req_q.wdata[2:0];
            else               tile_bank[2:0] <= req_q.wdata[2:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_a    <= '0;
            op_b    <= '0;
            product <= '0;
        end else begin
            if (wr && cs_mul && mreg == mreg_a) begin
                if (!req_q.dsn[1]) op_a[15:8] <= req_q.wdata[15:8];
                if (!req_q.dsn[0]) op_a[7:0]  <= req_q.wdata[7:0];
            end
            if (wr && cs_mul && mreg == mreg_b) begin
                if (!req_q.dsn[1]) op_b[15:8] <= req_q.wdata[15:8];
                if (!req_q.dsn[0]) op_b[7:0]  <= req_q.wdata[7:0];
            end
            product <= op_a * op_b;     // Follows the operands by one edge
        end
    end

    always_comb begin
        case (mreg)
            mreg_a:  mul_rdata = op_a;
            mreg_b:  mul_rdata = op_b;
            mreg_hi: mul_rdata = product[2*DATA_W-1:DATA_W];
            default: mul_rdata = product[DATA_W-1:0];
        endcase
    end

endmodule

// ==== rtl/s16b_bus_ctrl.sv ====
`timescale 1ns/1ns

module s16b_bus_ctrl #(
    parameter int FIXED_WAIT = 1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req,
    input  s16b_bus_pkg::s16b_host_req_t     host,
    output logic                             ack,
    output logic [s16b_bus_pkg::DATA_W-1:0]  rdata,
    output s16b_bus_pkg::s16b_host_req_t     req_q,
    output logic                             bus_active,
    output logic                             wr_stb,
    input  s16b_bus_pkg::s16b_cs_t           cs,
    input  logic [s16b_bus_pkg::DATA_W-1:0]  rom_data,
    input  logic                             rom_ok,
    input  logic [s16b_bus_pkg::DATA_W-1:0]  ram_data,
    input  logic                             ram_ok,
    input  s16b_bus_pkg::s16b_vid_rd_t       vid_rd,
    input  logic [s16b_bus_pkg::DATA_W-1:0]  mul_rdata
);

    import s16b_bus_pkg::*;

    localparam int CNT_MAX = (FIXED_WAIT > 1) ? FIXED_WAIT : 1;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_wait,
        st_hold,
        st_release
    } state_e;

    state_e            state;
    logic [CNT_W-1:0]  cnt;         // Cycles spent in st_wait, saturating
    logic              cs_valid;
    logic              ok;
    logic              done;
    logic [DATA_W-1:0] rd_mux;

    // Selects register one edge after bus_active
    assign cs_valid = cnt != '0;

    always_comb begin
        if (cs.ram || cs.vram) ok = ram_ok;
        else if (cs.rom)       ok = rom_ok;
        else                   ok = int'(cnt) >= FIXED_WAIT;   // Also unmapped
    end

    assign done   = (state == st_wait) && cs_valid && ok;
    assign wr_stb = done;

    always_comb begin
        if (cs.ram || cs.vram) rd_mux = ram_data;
        else if (cs.rom)       rd_mux = rom_data;
        else if (cs.chr)       rd_mux = vid_rd.chr_data;
        else if (cs.pal)       rd_mux = vid_rd.pal_data;
        else if (cs.obj)       rd_mux = vid_rd.obj_data;
        else if (cs.mul)       rd_mux = mul_rdata;
        else                   rd_mux = rdata;     // Unmapped keeps last value
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            ack        <= 1'b0;
            bus_active <= 1'b0;
            cnt        <= '0;
            rdata      <= '0;
            req_q      <= '{addr: '0, wdata: '0, rnw: 1'b1, dsn: 2'b11};
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        req_q <= host;
                        state <= st_select;
                    end
                end
                st_select: begin
                    bus_active <= 1'b1;
                    cnt        <= '0;
                    state      <= st_wait;
                end
                st_wait: begin
                    if (done) begin
                        ack   <= 1'b1;
                        rdata <= rd_mux;
                        state <= st_hold;
                    end else if (int'(cnt) < CNT_MAX) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_hold: begin
                    if (!req) begin
                        ack        <= 1'b0;
                        bus_active <= 1'b0;
                        state      <= st_release;
                    end
                end
                st_release: state <= st_idle;   // Selects clear on this edge
                default:    state <= st_idle;
            endcase
        end
    end

endmodule

// ==== rtl/s16b_main.sv ====
`timescale 1ns/1ns

module s16b_main #(
    parameter int FIXED_WAIT = 1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  s16b_board_pkg::pcb_e                pcb,
    input  logic                                req,
    input  s16b_bus_pkg::s16b_host_req_t        host,
    output logic                                ack,
    output logic [s16b_bus_pkg::DATA_W-1:0]     rdata,
    output s16b_bus_pkg::s16b_mem_cs_t          mem_cs,
    output logic [s16b_board_pkg::ROM_AW:1]     rom_addr,
    output logic [15:1]                         bus_addr,
    output logic [s16b_bus_pkg::DATA_W-1:0]     wdata,
    output logic                                udswn,
    output logic                                ldswn,
    input  logic [s16b_bus_pkg::DATA_W-1:0]     rom_data,
    input  logic                                rom_ok,
    input  logic [s16b_bus_pkg::DATA_W-1:0]     ram_data,
    input  logic                                ram_ok,
    input  s16b_bus_pkg::s16b_vid_rd_t          vid_rd,
    output logic [s16b_board_pkg::TBANK_W-1:0]  tile_bank
);

    import s16b_bus_pkg::*;

    s16b_host_req_t    req_q;
    s16b_cs_t          cs;
    region_e           region;
    logic              bus_active;
    logic              wr_stb;
    logic [DATA_W-1:0] mul_rdata;

    assign mem_cs   = '{rom: cs.rom, ram: cs.ram, vram: cs.vram,
                        chr: cs.chr, obj: cs.obj, pal: cs.pal};
    assign bus_addr = req_q.addr[15:1];
    assign wdata    = req_q.wdata;
    assign udswn    = req_q.rnw | req_q.dsn[1];   // Write strobes only
    assign ldswn    = req_q.rnw | req_q.dsn[0];

    s16b_region_decode i_region_decode (
        .pcb      (pcb),
        .addr     (req_q.addr),
        .region   (region),
        .rom_addr (rom_addr)
    );

    s16b_chip_select i_chip_select (
        .clk        (clk),
        .rst        (rst),
        .pcb        (pcb),
        .bus_active (bus_active),
        .region     (region),
        .req_q      (req_q),
        .cs         (cs)
    );

    s16b_sys_regs i_sys_regs (
        .clk       (clk),
        .rst       (rst),
        .cs_mul    (cs.mul),
        .cs_tbank  (cs.tbank),
        .wr_stb    (wr_stb),
        .req_q     (req_q),
        .mul_rdata (mul_rdata),
        .tile_bank (tile_bank)
    );

    s16b_bus_ctrl #(
        .FIXED_WAIT (FIXED_WAIT)
    ) i_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .host       (host),
        .ack        (ack),
        .rdata      (rdata),
        .req_q      (req_q),
        .bus_active (bus_active),
        .wr_stb     (wr_stb),
        .cs         (cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .ram_data   (ram_data),
        .ram_ok     (ram_ok),
        .vid_rd     (vid_rd),
        .mul_rdata  (mul_rdata)
    );

endmodule

// ==== test/s16b_bus_checker.sv ====
`timescale 1ns/1ns

module s16b_bus_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        req,
    input logic                        ack,
    input s16b_bus_pkg::s16b_mem_cs_t  mem_cs
);

    // Ack answers a request that was still up on the edge it rose
    ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    one_mem_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mem_cs))   // Memory selects are exclusive
        else $error("more than one memory select active");

endmodule

bind s16b_main s16b_bus_checker i_bus_checker (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .mem_cs (mem_cs)
);

// ==== test/s16b_main_tb.sv ====
`timescale 1ns/1ns

module s16b_main_tb;

    import s16b_bus_pkg::*;
    import s16b_board_pkg::*;

    localparam int N_TESTS         = 35;
    localparam int WATCHDOG_CYCLES = N_TESTS * 40 + 100;
    localparam logic RD = 1'b1;
    localparam logic WR = 1'b0;

    // mem_cs bit order is rom, ram, vram, chr, obj, pal
    localparam logic [5:0] CS_NONE = 6'b000000;
    localparam logic [5:0] CS_ROM  = 6'b100000;
    localparam logic [5:0] CS_RAM  = 6'b010000;
    localparam logic [5:0] CS_VRAM = 6'b001000;
    localparam logic [5:0] CS_CHR  = 6'b000100;
    localparam logic [5:0] CS_OBJ  = 6'b000010;
    localparam logic [5:0] CS_PAL  = 6'b000001;
    localparam logic [5:0] CS_WAITING = CS_ROM | CS_RAM | CS_VRAM;  // Targets with an ok signal

    typedef struct packed {
        pcb_e        pcb;
        logic [23:0] addr;          // Byte address
        logic        rnw;
        logic [1:0]  dsn;
        logic [15:0] wdata;
        logic [15:0] exp_rdata;     // Reads only
        logic [5:0]  exp_cs;
        logic [17:0] exp_rom;       // ROM accesses only
        logic [5:0]  exp_tbank;
    } test_t;

    logic                 clk;
    logic                 rst;
    pcb_e                 pcb;
    logic                 req;
    s16b_host_req_t       host;
    logic                 ack;
    logic [15:0]          rdata;
    s16b_mem_cs_t         mem_cs;
    logic [ROM_AW:1]      rom_addr;
    logic [15:1]          bus_addr;
    logic [15:0]          wdata;
    logic                 udswn;
    logic                 ldswn;
    logic [15:0]          rom_data = '0;
    logic                 rom_ok   = 1'b0;
    logic [15:0]          ram_data = '0;
    logic                 ram_ok   = 1'b0;
    s16b_vid_rd_t         vid_rd;
    logic [TBANK_W-1:0]   tile_bank;

    test_t       tests [N_TESTS];
    int          n_added  = 0;
    int          cur_test = -1;
    int          checks   = 0;
    int          errors   = 0;
    logic [15:0] ram_mem [0:32767];
    int          rom_wait = 0;
    int          ram_wait = 0;
    logic        served   = 1'b0;  // Current access already answered

    s16b_main #(
        .FIXED_WAIT (1)
    ) i_s16b_main (
        .clk       (clk),
        .rst       (rst),
        .pcb       (pcb),
        .req       (req),
        .host      (host),
        .ack       (ack),
        .rdata     (rdata),
        .mem_cs    (mem_cs),
        .rom_addr  (rom_addr),
        .bus_addr  (bus_addr),
        .wdata     (wdata),
        .udswn     (udswn),
        .ldswn     (ldswn),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .vid_rd    (vid_rd),
        .tile_bank (tile_bank)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM, work RAM and tile VRAM, each ok after a random delay
    always @(negedge clk) begin
        rom_data = rom_addr[16:1] ^ 16'h5a5a;
        ram_data = ram_mem[bus_addr];
        if (mem_cs == '0) begin
            served   = 1'b0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
            rom_wait = $urandom % 5;
            ram_wait = $urandom % 5;
        end else if (ack && !served) begin
            served = 1'b1;
            rom_ok = 1'b0;
            ram_ok = 1'b0;
            if (mem_cs.ram || mem_cs.vram) begin
                if (!udswn) ram_mem[bus_addr][15:8] = wdata[15:8];
                if (!ldswn) ram_mem[bus_addr][7:0]  = wdata[7:0];
            end
        end else if (!served) begin
            if (mem_cs.rom) begin
                if (rom_wait == 0) rom_ok = 1'b1;
                else rom_wait--;
            end
            if (mem_cs.ram || mem_cs.vram) begin
                if (ram_wait == 0) ram_ok = 1'b1;
                else ram_wait--;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns, test %0d: %s is %h, expected %h",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic add_test(input pcb_e p, input logic [23:0] a, input logic rnw,
                            input logic [1:0] dsn, input logic [15:0] wd,
                            input logic [15:0] rd, input logic [5:0] cs,
                            input logic [17:0] ra, input logic [5:0] tb);
        if (n_added < N_TESTS) tests[n_added] = '{p, a, rnw, dsn, wd, rd, cs, ra, tb};
        n_added++;
    endtask

    // ROM data is the low 16 bits of rom_addr xor 5a5a
    task automatic fill_table();
        add_test(pcb_5521, 24'h05a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h0d234, 6'h00);
        add_test(pcb_5521, 24'h3b3c8e, RD, 2'b00, 16'h0, 16'hc41d, CS_ROM, 18'h39e47, 6'h00);
        add_test(pcb_5521, 24'h45a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h0d234, 6'h00);
        add_test(pcb_5358_large, 24'h5b3c8e, RD, 2'b00, 16'h0, 16'hc41d, CS_ROM, 18'h29e47, 6'h00);
        add_test(pcb_5358_large, 24'h25a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h1d234, 6'h00);
        add_test(pcb_5358_small, 24'h1b3c8e, RD, 2'b00, 16'h0, 16'h441d, CS_ROM, 18'h01e47, 6'h00);
        add_test(pcb_5358_small, 24'h45a468, RD, 2'b00, 16'h0, 16'h086e, CS_ROM, 18'h15234, 6'h00);
        add_test(pcb_5358_small, 24'h25a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h0d234, 6'h00);
        add_test(pcb_korean, 24'h3b3c8e, RD, 2'b00, 16'h0, 16'hc41d, CS_ROM, 18'h19e47, 6'h00);
        add_test(pcb_korean, 24'h45a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h0d234, 6'h00);
        add_test(pcb_5797, 24'h1b3c8e, RD, 2'b00, 16'h0, 16'hc41d, CS_ROM, 18'h19e47, 6'h00);
        add_test(pcb_5797, 24'h05a468, RD, 2'b00, 16'h0, 16'h886e, CS_ROM, 18'h2d234, 6'h00);
        // io region keeps the last read word
        add_test(pcb_5521, 24'he00000, RD, 2'b00, 16'h0, 16'h886e, CS_NONE, 18'h0, 6'h00);
        // Work RAM byte merging
        add_test(pcb_5521, 24'h600100, WR, 2'b00, 16'h1234, 16'h0, CS_RAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'h600100, WR, 2'b01, 16'habcd, 16'h0, CS_RAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'h600100, WR, 2'b10, 16'h5566, 16'h0, CS_RAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'h600100, RD, 2'b00, 16'h0, 16'hab66, CS_RAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'ha00200, WR, 2'b00, 16'h7788, 16'h0, CS_VRAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'ha00200, RD, 2'b00, 16'h0, 16'h7788, CS_VRAM, 18'h0, 6'h00);
        add_test(pcb_5521, 24'ha10040, RD, 2'b00, 16'h0, 16'hc0de, CS_CHR, 18'h0, 6'h00);
        add_test(pcb_5521, 24'hc00010, RD, 2'b00, 16'h0, 16'h9a1e, CS_PAL, 18'h0, 6'h00);
        add_test(pcb_5521, 24'h800020, RD, 2'b00, 16'h0, 16'h0b1e, CS_OBJ, 18'h0, 6'h00);
        // Tile bank fields, bit 1 picks the upper field
        add_test(pcb_5521, 24'h400000, WR, 2'b10, 16'h0005, 16'h0, CS_NONE, 18'h0, 6'h05);
        add_test(pcb_5521, 24'h400002, WR, 2'b10, 16'h0003, 16'h0, CS_NONE, 18'h0, 6'h1d);
        add_test(pcb_5797, 24'h202000, WR, 2'b10, 16'h0002, 16'h0, CS_NONE, 18'h0, 6'h1a);
        add_test(pcb_5797, 24'h202002, WR, 2'b10, 16'h0006, 16'h0, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h400002, WR, 2'b10, 16'h0007, 16'h0, CS_NONE, 18'h0, 6'h32);
        // -200 * 309 = ffff0e98
        add_test(pcb_5797, 24'h200000, WR, 2'b01, 16'hff00, 16'h0, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h200000, WR, 2'b10, 16'h1238, 16'h0, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h200002, WR, 2'b00, 16'h0135, 16'h0, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h200000, RD, 2'b00, 16'h0, 16'hff38, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h200004, RD, 2'b00, 16'h0, 16'hffff, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h200006, RD, 2'b00, 16'h0, 16'h0e98, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h400000, RD, 2'b00, 16'h0, 16'h0e98, CS_NONE, 18'h0, 6'h32);
        add_test(pcb_5797, 24'h201000, RD, 2'b00, 16'h0, 16'h0e98, CS_NONE, 18'h0, 6'h32);
    endtask

    // One four-phase access, entered and left on a falling edge
    task automatic run_test(input int idx);
        test_t t;
        int    cycles;
        cur_test = idx;
        t        = tests[idx];
        cycles   = 0;
        pcb      = t.pcb;
        host     = '{addr: t.addr[23:1], wdata: t.wdata, rnw: t.rnw, dsn: t.dsn};
        req      = 1'b1;
        @(negedge clk);     // Request edge now behind
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack);
        check_value("mem_cs", mem_cs, t.exp_cs);
        if ((t.exp_cs & CS_ROM) != '0) check_value("rom_addr", rom_addr, t.exp_rom);
        check_value("bus_addr", bus_addr, t.addr[15:1]);
        if (t.rnw) check_value("rdata", rdata, t.exp_rdata);
        check_value("udswn", udswn, t.rnw | t.dsn[1]);
        check_value("ldswn", ldswn, t.rnw | t.dsn[0]);
        check_value("tile_bank", tile_bank, t.exp_tbank);
        if ((t.exp_cs & CS_WAITING) == '0) check_value("ack latency", cycles, 3);
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
        @(negedge clk);
        check_value("mem_cs after release", mem_cs, CS_NONE);
    endtask

    initial begin
        void'($urandom(40));
        rst    = 1'b1;
        req    = 1'b0;
        pcb    = pcb_5521;
        host   = '{addr: '0, wdata: '0, rnw: 1'b1, dsn: 2'b11};
        vid_rd = '{chr_data: 16'hc0de, pal_data: 16'h9a1e, obj_data: 16'h0b1e};
        for (int i = 0; i < 32768; i++) ram_mem[i] = 16'(i) ^ 16'h5aa5;
        fill_table();
        check_value("stimulus table size", n_added, N_TESTS);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("ack after reset", ack, 0);
        check_value("mem_cs after reset", mem_cs, 0);
        check_value("tile_bank after reset", tile_bank, 0);
        check_value("rdata after reset", rdata, 0);
        for (int i = 0; i < N_TESTS; i++) run_test(i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout: the DUT stopped answering during test %0d", cur_test);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/s16b_bus_pkg.sv
rtl/s16b_board_pkg.sv
rtl/s16b_region_decode.sv
rtl/s16b_chip_select.sv
rtl/s16b_sys_regs.sv
rtl/s16b_bus_ctrl.sv
rtl/s16b_main.sv
test/s16b_bus_checker.sv
test/s16b_main_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= s16b_main_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
